// File: verilog.f
source/vic_video_pkg.sv
source/vga_timing_pkg.sv
source/vga_scan_ctrl.sv
source/line_buffer.sv
source/vga_pixel_path.sv
source/vga_scan_doubler.sv
bench/vga_scan_doubler_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scan doubler testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

top=vga_scan_doubler_tb
log=sim.log

verilator --binary --assert -f verilog.f --top-module "$top" -o "$top" --Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"

# The log decides the result
if grep -q "test failed" "$log"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: bench/vga_scan_doubler_tb.sv
`default_nettype none

module vga_scan_doubler_tb;

   localparam int hs_sta        = 16;   // Same for every chip
   localparam int hs_low_clocks = 64;   // hs_sta to hs_end, two clocks per VGA pixel
   localparam int vs_low_lines  = 3;

   // One row per chip, expected timing as seen on the outputs
   typedef struct packed {
      vic_video_pkg::chip_model chip;
      int line_clocks;
      int frame_lines;
      int hoffset;
      int ha_sta;
      int va_end;
      int vs_sta;
   } chip_row;

   logic                     clk_dot4x = 1'b0;
   logic                     rst;
   vic_video_pkg::chip_model chip;
   logic [9:0]               raster_x;
   vic_video_pkg::vic_color  pixel_color3;
   logic                     hsync;
   logic                     vsync;
   vic_video_pkg::vic_color  pixel_color4;

   chip_row                  rows [3];
   int                       cur;
   int                       sw;              // Last raster_x of a native line
   string                    test_name;
   vic_video_pkg::chip_model chip_drive;
   int                       clk_count;       // Clocks since reset release
   logic [9:0]               vic_x;
   logic [3:0]               seed_cur;        // Seed of the native line being sent
   logic [3:0]               completed_seed;
   logic                     completed_valid;
   logic [3:0]               line_seed;       // Seed shown on the current VGA line
   logic                     line_seed_valid;
   int                       hs_in_window;    // VGA lines per native line
   logic                     hs_prev;
   logic                     vs_prev;
   logic                     hs_fall_seen;
   int                       last_hs_fall;
   int                       hs_since_vs;
   int                       vs_falls;
   logic                     v_known;
   int                       line_v;          // VGA line index, valid once v_known

   vga_scan_doubler vga_scan_doubler_i (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .chip         (chip),
      .raster_x     (raster_x),
      .pixel_color3 (pixel_color3),
      .hsync        (hsync),
      .vsync        (vsync),
      .pixel_color4 (pixel_color4)
   );

   always #2 clk_dot4x = ~clk_dot4x;

   task automatic compare_value(input string check, input int expected, input int actual);
      if (expected != actual) begin
         $display("FAILED %s %s: expected %0d, actual %0d", test_name, check, expected, actual);
         $display("test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic report_error(input string what);
      $display("ERROR %s: %s", test_name, what);
      $display("test failed");
      $fatal(1, "stopped on error");
   endtask

   // VIC color for a native dot, x mod 16 mixed with the line seed
   function automatic vic_video_pkg::vic_color dot_pattern(input logic [9:0] x,
                                                           input logic [3:0] seed);
      return vic_video_pkg::vic_color'(x[3:0] ^ seed);
   endfunction

   task automatic check_reset_state();
      compare_value("reset hsync", 1, int'(hsync));
      compare_value("reset vsync", 1, int'(vsync));
      compare_value("reset color", int'(vic_video_pkg::BLACK), int'(pixel_color4));
   endtask

   task automatic reset_dut(input int idx);
      int i;
      cur        = idx;
      chip_drive = rows[idx].chip;
      sw         = rows[idx].line_clocks / 2 - 1;
      test_name  = chip_drive.name();
      if (idx != 0) begin                  // Row 0 starts with rst already high
         @(posedge clk_dot4x);
         rst  <= 1'b1;
         chip <= chip_drive;
      end
      for (i = 0; i < 2; i++) begin
         @(posedge clk_dot4x);
         if (i == 1) begin
            rst          <= 1'b0;
            seed_cur     = 4'($urandom);
            vic_x        = 10'd0;
            raster_x     <= vic_x;          // First native dot, held four clocks
            pixel_color3 <= dot_pattern(vic_x, seed_cur);
         end
         @(negedge clk_dot4x);
         check_reset_state();
      end
      clk_count       = 0;
      completed_valid = 1'b0;
      line_seed_valid = 1'b0;
      hs_in_window    = 0;
      hs_prev         = 1'b1;
      vs_prev         = 1'b1;
      hs_fall_seen    = 1'b0;
      last_hs_fall    = 0;
      hs_since_vs     = 0;
      vs_falls        = 0;
      v_known         = 1'b0;
      line_v          = 0;
   endtask

   // VIC side, one native dot every four clocks
   task automatic drive_vic();
      chip <= chip_drive;
      if (clk_count % 4 == 0) begin
         if (vic_x == 10'(sw)) begin
            compare_value("VGA lines per native line", 2, hs_in_window);
            hs_in_window    = 0;
            completed_seed  = seed_cur;
            completed_valid = 1'b1;
            seed_cur        = 4'($urandom);
            vic_x           = 10'd0;
         end else begin
            vic_x = vic_x + 10'd1;
         end
         raster_x     <= vic_x;
         pixel_color3 <= dot_pattern(vic_x, seed_cur);
      end
   endtask

   task automatic monitor_outputs();
      int c;
      int h_pos;
      if (clk_count == 1)
         check_reset_state();
      // hsync falls at h = hs_sta of each VGA line
      if (hs_prev && !hsync) begin
         if (hs_fall_seen)
            compare_value("hsync period", rows[cur].line_clocks, clk_count - last_hs_fall);
         hs_fall_seen    = 1'b1;
         last_hs_fall    = clk_count;
         hs_in_window    = hs_in_window + 1;
         hs_since_vs     = hs_since_vs + 1;
         line_v          = (line_v + 1) % rows[cur].frame_lines;
         line_seed       = completed_seed;
         line_seed_valid = completed_valid;
      end
      if (!hs_prev && hsync && hs_fall_seen)
         compare_value("hsync low clocks", hs_low_clocks, clk_count - last_hs_fall);
      if (vs_prev && !vsync) begin
         if (vs_falls > 0)
            compare_value("vsync period in lines", rows[cur].frame_lines, hs_since_vs);
         vs_falls    = vs_falls + 1;
         hs_since_vs = 0;
         v_known     = 1'b1;
         line_v      = rows[cur].vs_sta - 1;   // Next hsync fall opens line vs_sta
      end
      if (!vs_prev && vsync && vs_falls > 0)
         compare_value("vsync low lines", vs_low_lines, hs_since_vs);

      if (clk_count - last_hs_fall > rows[cur].line_clocks + 4)
         report_error("no falling edge of hsync within one line time");
      if (!hsync && clk_count - last_hs_fall > hs_low_clocks + 4)
         report_error("hsync stuck low");
      if (hs_since_vs > rows[cur].frame_lines + 1)
         report_error("no falling edge of vsync within one frame");
      if (!vsync && hs_since_vs > vs_low_lines + 1)
         report_error("vsync stuck low");

      if (hs_fall_seen) begin
         c     = clk_count - last_hs_fall;
         h_pos = hs_sta + c / 2;
         if (h_pos > sw)
            h_pos = h_pos - (sw + 1);         // Left border of the next line
         if (h_pos < rows[cur].ha_sta)
            compare_value("horizontal blanking", int'(vic_video_pkg::BLACK),
                          int'(pixel_color4));
         else if (v_known && line_v >= rows[cur].va_end)
            compare_value("vertical blanking", int'(vic_video_pkg::BLACK),
                          int'(pixel_color4));
         else if (v_known && line_seed_valid)
            compare_value("doubled pixel",
                          int'(dot_pattern(10'(h_pos - rows[cur].hoffset), line_seed)),
                          int'(pixel_color4));
      end
      hs_prev = hsync;
      vs_prev = vsync;
   endtask

   task automatic run_clocks(input int n);
      int i;
      for (i = 0; i < n; i++) begin
         @(posedge clk_dot4x);
         clk_count = clk_count + 1;
         drive_vic();
         @(negedge clk_dot4x);
         monitor_outputs();
      end
   endtask

   initial begin
      int r;
      void'($urandom(53565));
      //          chip                        clocks lines hoff ha_sta va_end vs_sta
      rows[0] = '{vic_video_pkg::CHIP6569,     1008,  624,  29,  65,    569,   580};
      rows[1] = '{vic_video_pkg::CHIP6567R8,   1040,  526,  32,  65,    502,   512};
      rows[2] = '{vic_video_pkg::CHIP6567R56A, 1024,  524,  32,  65,    502,   512};
      chip_drive   = rows[0].chip;
      rst          <= 1'b1;
      chip         <= rows[0].chip;
      raster_x     <= 10'd0;
      pixel_color3 <= vic_video_pkg::BLACK;

      for (r = 0; r < 3; r++) begin
         reset_dut(r);
         // A bit over one frame, enough for two vsync periods
         run_clocks((rows[r].frame_lines + 40) * rows[r].line_clocks);
         if (vs_falls < 2)
            report_error("fewer than two vsync falling edges in the run");
      end

      // Chip input is only sampled in reset, timing must stay that of the last row
      test_name  = "chip change out of reset";
      chip_drive = rows[0].chip;
      run_clocks(6 * rows[2].line_clocks);

      $display("test passed");
      $finish;
   end

endmodule : vga_scan_doubler_tb

`default_nettype wire

// File: source/vga_scan_doubler.sv
`default_nettype none

module vga_scan_doubler #(
   parameter int line_depth = 520         // Widest native line
) (
   input  wire                           clk_dot4x,
   input  wire                           rst,
   input  wire vic_video_pkg::chip_model chip,
   input  wire [9:0]                     raster_x,
   input  wire vic_video_pkg::vic_color  pixel_color3,
   output logic                          hsync,
   output logic                          vsync,
   output vic_video_pkg::vic_color       pixel_color4
);

   logic                    dot_strobe;
   logic                    write_bank;
   vga_timing_pkg::buf_read rd;
   vic_video_pkg::vic_color rd_data;

   vga_scan_ctrl #(
      .line_depth (line_depth)
   ) vga_scan_ctrl_i (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .chip       (chip),
      .raster_x   (raster_x),
      .dot_strobe (dot_strobe),
      .write_bank (write_bank),
      .rd         (rd)
   );

   line_buffer #(
      .line_depth (line_depth),
      .pixel_t    (vic_video_pkg::vic_color)
   ) line_buffer_i (
      .clk_dot4x (clk_dot4x),
      .wr_en     (dot_strobe),      // One write per native dot
      .wr_bank   (write_bank),
      .wr_addr   (raster_x),
      .wr_data   (pixel_color3),
      .rd        (rd),
      .rd_data   (rd_data)
   );

   vga_pixel_path vga_pixel_path_i (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .rd           (rd),
      .rd_data      (rd_data),
      .hsync        (hsync),
      .vsync        (vsync),
      .pixel_color4 (pixel_color4)
   );

endmodule : vga_scan_doubler

`default_nettype wire

// File: source/vga_pixel_path.sv
`default_nettype none

module vga_pixel_path (
   input  wire                          clk_dot4x,
   input  wire                          rst,
   input  wire vga_timing_pkg::buf_read rd,
   input  wire vic_video_pkg::vic_color rd_data,
   output logic                         hsync,
   output logic                         vsync,
   output vic_video_pkg::vic_color      pixel_color4
);

   vga_timing_pkg::buf_read rd_q;       // Lines up with rd_data
   logic                    show;

   assign show = rd_q.active & rd_q.shown;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         rd_q <= '{bank: 1'b1, addr: 10'd0, shown: 1'b0,
                   hsync: 1'b1, vsync: 1'b1, active: 1'b0};
      end else begin
         rd_q <= rd;
      end
   end

   // Output stage, syncs stay aligned with the color
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         hsync        <= 1'b1;
         vsync        <= 1'b1;
         pixel_color4 <= vic_video_pkg::BLACK;
      end else begin
         hsync        <= rd_q.hsync;
         vsync        <= rd_q.vsync;
         pixel_color4 <= show ? rd_data : vic_video_pkg::BLACK;   // Blank outside active
      end
   end

endmodule : vga_pixel_path

`default_nettype wire

// File: source/line_buffer.sv
`default_nettype none

module line_buffer #(
   parameter int  line_depth = 520,
   parameter type pixel_t    = vic_video_pkg::vic_color
) (
   input  wire                     clk_dot4x,
   input  wire                     wr_en,
   input  wire                     wr_bank,
   input  wire [9:0]               wr_addr,
   input  wire pixel_t             wr_data,
   input  wire vga_timing_pkg::buf_read rd,
   output pixel_t                  rd_data
);

   // One native line per bank
   pixel_t mem0 [line_depth];
   pixel_t mem1 [line_depth];

   always_ff @(posedge clk_dot4x) begin
      if (wr_en) begin
         if (wr_bank)
            mem1[wr_addr] <= wr_data;
         else
            mem0[wr_addr] <= wr_data;
      end
   end

   // Registered read, rd.bank is never the bank being written
   always_ff @(posedge clk_dot4x) begin
      if (rd.bank)
         rd_data <= mem1[rd.addr];
      else
         rd_data <= mem0[rd.addr];
   end

   // raster_x must stay inside the memory
   wr_addr_in_range: assert property (@(posedge clk_dot4x)
      wr_en |-> (wr_addr < 10'(line_depth)));

endmodule : line_buffer

`default_nettype wire

// File: source/vga_scan_ctrl.sv
`default_nettype none

module vga_scan_ctrl #(
   parameter int line_depth = 520
) (
   input  wire                        clk_dot4x,
   input  wire                        rst,
   input  wire vic_video_pkg::chip_model chip,
   input  wire [9:0]                  raster_x,
   output logic                       dot_strobe,
   output logic                       write_bank,
   output vga_timing_pkg::buf_read    rd
);

   vga_timing_pkg::vga_timing tm;        // Timing latched during reset
   vga_timing_pkg::vga_timing tm_reset;
   logic [3:0] phase;                    // One-hot native dot phase
   logic       parity;                   // VGA pixel is two clocks
   logic       bank_q;
   logic [9:0] h_count;
   logic [9:0] v_count;
   logic [9:0] h_next;
   logic [9:0] v_next;
   logic [9:0] rd_addr_next;
   logic       rd_shown_next;

   assign tm_reset = vga_timing_pkg::timing_for_chip(chip);

   // First native dot strobe comes on the fourth edge after reset
   assign dot_strobe = phase[3];

   // Swap banks when the native line restarts
   assign write_bank = bank_q ^ (dot_strobe & (raster_x == 10'd0));

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase  <= 4'b0001;
         bank_q <= 1'b0;
      end else begin
         phase  <= {phase[2:0], phase[3]};
         bank_q <= write_bank;
      end
   end

   // Next counter values let rd register on the same edge as the counters
   always_comb begin
      h_next = h_count;
      v_next = v_count;
      if (parity) begin
         if (h_count < tm.screen_width) begin
            h_next = h_count + 10'd1;
         end else begin
            h_next = 10'd0;
            if (v_count < tm.screen_height)
               v_next = v_count + 10'd1;
            else
               v_next = 10'd0;
         end
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tm      <= tm_reset;
         parity  <= 1'b0;
         h_count <= 10'd0;
         v_count <= tm_reset.v_start;
      end else begin
         parity  <= ~parity;
         h_count <= h_next;
         v_count <= v_next;
      end
   end

   // Line buffer position of the next VGA pixel
   assign rd_addr_next  = h_next - tm.hoffset;
   assign rd_shown_next = (h_next >= tm.hoffset) && (rd_addr_next < 10'(line_depth));

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         rd <= '{bank: 1'b1, addr: 10'd0, shown: 1'b0,
                 hsync: 1'b1, vsync: 1'b1, active: 1'b0};
      end else begin
         rd.bank   <= ~write_bank;      // Always the half not being filled
         rd.addr   <= rd_shown_next ? rd_addr_next : 10'd0;
         rd.shown  <= rd_shown_next;
         rd.hsync  <= ~((h_next >= tm.hs_sta) && (h_next < tm.hs_end));
         rd.vsync  <= ~((v_next >= tm.vs_sta) && (v_next < tm.vs_end));
         rd.active <= (h_next >= tm.ha_sta) && (v_next < tm.va_end);
      end
   end

   // Native line must end within the VGA line width latched at reset
   raster_x_in_line: assert property (@(posedge clk_dot4x) disable iff (rst)
      dot_strobe |-> (raster_x <= tm.screen_width));

   // Line count stays inside the frame latched at reset
   v_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
      v_count <= tm.screen_height);

endmodule : vga_scan_ctrl

`default_nettype wire

// File: source/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

   // Horizontal and vertical timing of the doubled output, in VGA pixels and lines
   typedef struct packed {
      logic [9:0] screen_width;   // Last horizontal index
      logic [9:0] screen_height;  // Last line index
      logic [9:0] hs_sta;
      logic [9:0] hs_end;
      logic [9:0] ha_sta;         // First active pixel
      logic [9:0] vs_sta;
      logic [9:0] vs_end;
      logic [9:0] va_end;         // First inactive line
      logic [9:0] hoffset;        // Native to VGA horizontal shift
      logic [9:0] v_start;        // Line count loaded at reset
   } vga_timing;

   // Read request and the sync state that goes with it
   typedef struct packed {
      logic       bank;
      logic [9:0] addr;
      logic       shown;          // Read position at or past hoffset
      logic       hsync;
      logic       vsync;
      logic       active;
   } buf_read;

   function automatic vga_timing timing_for_chip(input vic_video_pkg::chip_model chip);
      vga_timing t;
      t.hs_sta = 10'd16;
      t.hs_end = 10'd48;
      t.ha_sta = 10'd65;
      case (chip)
         vic_video_pkg::CHIP6567R8: begin
            t.screen_width  = 10'd519;
            t.screen_height = 10'd525;
            t.hoffset       = 10'd32;
            t.vs_sta        = 10'd512;
            t.vs_end        = 10'd515;
            t.va_end        = 10'd502;
            t.v_start       = 10'd485;
         end
         vic_video_pkg::CHIP6567R56A: begin
            t.screen_width  = 10'd511;
            t.screen_height = 10'd523;
            t.hoffset       = 10'd32;
            t.vs_sta        = 10'd512;
            t.vs_end        = 10'd515;
            t.va_end        = 10'd502;
            t.v_start       = 10'd483;
         end
         default: begin             // 6569 and the unused code
            t.screen_width  = 10'd503;
            t.screen_height = 10'd623;
            t.hoffset       = 10'd29;
            t.vs_sta        = 10'd580;
            t.vs_end        = 10'd583;
            t.va_end        = 10'd569;
            t.v_start       = 10'd560;
         end
      endcase
      return t;
   endfunction

endpackage : vga_timing_pkg

`default_nettype wire

// File: source/vic_video_pkg.sv
`default_nettype none

package vic_video_pkg;

   // The sixteen VIC color indices, in hardware order
   typedef enum logic [3:0] {
      BLACK       = 4'd0,   // Also the blanking color
      WHITE       = 4'd1,
      RED         = 4'd2,
      CYAN        = 4'd3,
      PURPLE      = 4'd4,
      GREEN       = 4'd5,
      BLUE        = 4'd6,
      YELLOW      = 4'd7,
      ORANGE      = 4'd8,
      BROWN       = 4'd9,
      PINK        = 4'd10,
      DARK_GREY   = 4'd11,
      GREY        = 4'd12,
      LIGHT_GREEN = 4'd13,
      LIGHT_BLUE  = 4'd14,
      LIGHT_GREY  = 4'd15
   } vic_color;

   // Chip variants, CHIPUNUSED behaves as the PAL part
   typedef enum logic [1:0] {
      CHIP6569     = 2'd0,   // PAL
      CHIPUNUSED   = 2'd1,
      CHIP6567R8   = 2'd2,   // NTSC, 65 cycles per line
      CHIP6567R56A = 2'd3    // Old NTSC, 64 cycles per line
   } chip_model;

endpackage : vic_video_pkg

`default_nettype wire
